//--- project.f
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/ctrlIf.sv
verilog/Control.sv
verilog/RegFile.sv
verilog/Alu.sv
verilog/DataMem.sv
verilog/InstrSeq.sv
verilog/ExecCore.sv
testbench/tbClock.sv
testbench/tbExecCore.sv

//--- testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic arstN
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
    end
endmodule

//--- testbench/tbExecCore.sv
`timescale 1ns/1ps

module tbExecCore;
    localparam int WAIT_LIMIT = 64;

    logic        clk;
    logic        arstN;
    logic        instrReq;
    logic [31:0] instr;
    logic        instrAck;
    logic [31:0] pc;
    logic        wbValid;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    logic [31:0] lfsr = 32'hbc4a_c1dc;
    logic [31:0] mRegs [32];
    logic [31:0] mMem [ctrlPkg::MEM_WORDS];
    logic [31:0] mPc;
    logic [31:0] expPc;
    logic        expWbValid;
    logic [4:0]  expWbAddr;
    logic [31:0] expWbData;
    int          errors;
    int          sent;

    logic [5:0] immOps [8] = '{isaPkg::OP_ADDI, isaPkg::OP_ADDIU, isaPkg::OP_SLTI,
        isaPkg::OP_SLTIU, isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI, isaPkg::OP_LUI};
    logic [5:0] rFuncs [9] = '{isaPkg::FUNC_ADDU, isaPkg::FUNC_SUBU, isaPkg::FUNC_AND,
        isaPkg::FUNC_OR, isaPkg::FUNC_XOR, isaPkg::FUNC_SLT, isaPkg::FUNC_SLL,
        isaPkg::FUNC_SRL, isaPkg::FUNC_SRLV};

    tbClock tbClock_inst (.clk(clk), .arstN(arstN));

    ExecCore ExecCore_inst (
        .clk(clk), .arstN(arstN), .instrReq(instrReq), .instr(instr),
        .instrAck(instrAck), .pc(pc), .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
    );

    // --------------------
    // Checks
    // --------------------
    assert property (@(posedge clk) disable iff (!arstN) $rose(instrAck) |-> pc == expPc)
        else begin
            errors++;
            $display("ERR pc: got %h, expected %h", $sampled(pc), expPc);
        end
    assert property (@(posedge clk) disable iff (!arstN)
        $rose(instrAck) |-> wbValid == expWbValid)
        else begin
            errors++;
            $display("ERR wbValid: got %h, expected %h", $sampled(wbValid), expWbValid);
        end
    assert property (@(posedge clk) disable iff (!arstN) wbValid |-> wbAddr == expWbAddr)
        else begin
            errors++;
            $display("ERR wbAddr: got %h, expected %h", $sampled(wbAddr), expWbAddr);
        end
    assert property (@(posedge clk) disable iff (!arstN) wbValid |-> wbData == expWbData)
        else begin
            errors++;
            $display("ERR wbData: got %h, expected %h", $sampled(wbData), expWbData);
        end
    assert property (@(posedge clk) disable iff (!arstN) wbValid |-> $rose(instrAck))
        else begin
            errors++;
            $display("wbValid was high outside the first acknowledged cycle");
        end
    assert property (@(posedge clk) disable iff (!arstN) $changed(pc) |-> $rose(instrAck))
        else begin
            errors++;
            $display("pc changed without a new request being executed");
        end
    assert property (@(posedge clk) disable iff (!arstN)
        $rose(instrAck) |-> $past(instrReq) && !$past(instrReq, 2))
        else begin
            errors++;
            $display("instrAck rose other than one cycle after a new request");
        end
    assert property (@(posedge clk) disable iff (!arstN) instrReq && instrAck |=> instrAck)
        else begin
            errors++;
            $display("instrAck dropped while instrReq was still high");
        end
    assert property (@(posedge clk) disable iff (!arstN)
        $fell(instrAck) |-> $past(instrReq, 3) && !$past(instrReq, 2))
        else begin
            errors++;
            $display("instrAck did not fall one cycle after instrReq was seen low");
        end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {isaPkg::OP_ZERO, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    function automatic logic [31:0] randomAluInstr();
        int sel;
        sel = randBits(5) % 17;
        if (sel < 8) begin
            return iType(immOps[sel], randBits(5), randBits(5), randBits(16));
        end
        return rType(rFuncs[sel - 8], randBits(5), randBits(5), randBits(5), randBits(5));
    endfunction

    // --------------------
    // Reference model
    // --------------------
    task automatic predict(input logic [31:0] w);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immS;
        logic [31:0] immZ;
        logic [31:0] addr;
        logic [31:0] pc4;
        logic [31:0] nextPc;
        logic [31:0] res;
        logic [31:0] word;
        logic [7:0]  lane8;
        logic [15:0] lane16;
        logic [7:0]  idx;
        logic [4:0]  dst;
        logic        wr;
        op     = w[31:26];
        fn     = w[5:0];
        a      = mRegs[w[25:21]];
        b      = mRegs[w[20:16]];
        immS   = {{16{w[15]}}, w[15:0]};
        immZ   = {16'd0, w[15:0]};
        addr   = a + immS;
        idx    = addr[9:2];
        word   = mMem[idx];
        lane8  = word[8 * addr[1:0] +: 8];
        lane16 = addr[1] ? word[31:16] : word[15:0];
        pc4    = mPc + 32'd4;
        nextPc = pc4;
        dst    = w[20:16];
        wr     = 1'b1;
        res    = '0;
        case (op)
            isaPkg::OP_ZERO: begin
                dst = w[15:11];
                case (fn)
                    isaPkg::FUNC_ADDU: res = a + b;
                    isaPkg::FUNC_SUBU: res = a - b;
                    isaPkg::FUNC_AND:  res = a & b;
                    isaPkg::FUNC_OR:   res = a | b;
                    isaPkg::FUNC_XOR:  res = a ^ b;
                    isaPkg::FUNC_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    isaPkg::FUNC_SLL:  res = b << w[10:6];
                    isaPkg::FUNC_SRL:  res = b >> w[10:6];
                    isaPkg::FUNC_SRLV: res = b >> a[4:0];
                    isaPkg::FUNC_JALR: begin
                        res    = pc4;
                        nextPc = a;
                    end
                    isaPkg::FUNC_JR: begin
                        wr     = 1'b0;
                        nextPc = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            isaPkg::OP_ADDI, isaPkg::OP_ADDIU: res = a + immS;  // No overflow trap
            isaPkg::OP_SLTI:  res = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
            isaPkg::OP_SLTIU: res = (a < immS) ? 32'd1 : 32'd0;
            isaPkg::OP_ANDI:  res = a & immZ;
            isaPkg::OP_ORI:   res = a | immZ;
            isaPkg::OP_XORI:  res = a ^ immZ;
            isaPkg::OP_LUI:   res = {w[15:0], 16'd0};
            isaPkg::OP_LB:    res = {{24{lane8[7]}}, lane8};
            isaPkg::OP_LBU:   res = {24'd0, lane8};
            isaPkg::OP_LH:    res = {{16{lane16[15]}}, lane16};
            isaPkg::OP_LHU:   res = {16'd0, lane16};
            isaPkg::OP_LW, isaPkg::OP_LWU: res = word;
            isaPkg::OP_SB: begin
                wr = 1'b0;
                mMem[idx][8 * addr[1:0] +: 8] = b[7:0];
            end
            isaPkg::OP_SH: begin
                wr = 1'b0;
                mMem[idx][16 * addr[1] +: 16] = b[15:0];
            end
            isaPkg::OP_SW: begin
                wr = 1'b0;
                mMem[idx] = b;
            end
            isaPkg::OP_BEQ, isaPkg::OP_BNE: begin
                wr = 1'b0;
                if ((a == b) == (op == isaPkg::OP_BEQ)) begin
                    nextPc = pc4 + {immS[29:0], 2'b00};
                end
            end
            isaPkg::OP_J, isaPkg::OP_JAL: begin
                wr     = (op == isaPkg::OP_JAL);
                dst    = isaPkg::REG_LINK;
                res    = pc4;
                nextPc = {pc4[31:28], w[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        expWbValid = wr && (dst != 5'd0);
        expWbAddr  = dst;
        expWbData  = res;
        if (expWbValid) begin
            mRegs[dst] = res;
        end
        mPc   = nextPc;
        expPc = nextPc;
    endtask

    task automatic abortOnStall(input string why);
        $display("Stalled: %s", why);
        $display("Done: errors found");
        $finish;
    endtask

    // Four-phase request for one instruction held for extra cycles
    task automatic send(input logic [31:0] w, input int hold);
        int waitCnt;
        repeat (randBits(2)) @(posedge clk);  // Idle gap
        predict(w);
        @(posedge clk);
        instrReq <= 1'b1;
        instr    <= w;
        waitCnt = 0;
        @(negedge clk);
        while (!instrAck && waitCnt < WAIT_LIMIT) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!instrAck) abortOnStall($sformatf("no instrAck for instruction %h", w));
        repeat (hold) @(posedge clk);
        @(posedge clk);
        instrReq <= 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (instrAck && waitCnt < WAIT_LIMIT) begin
            @(negedge clk);
            waitCnt++;
        end
        if (instrAck) abortOnStall("instrAck stayed high after instrReq fell");
        sent++;
    endtask

    task automatic finishTest(input int n, input string name);
        $display("Test %0d (%s) finished, %0d errors so far", n, name, errors);
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        logic [4:0] r;
        logic [7:0] idx8;
        logic [1:0] lane;
        int         waitCnt;
        instrReq = 1'b0;
        instr    = '0;
        errors   = 0;
        sent     = 0;
        mPc      = '0;
        expPc    = '0;
        expWbValid = 1'b0;
        expWbAddr  = '0;
        expWbData  = '0;
        foreach (mRegs[i]) mRegs[i] = '0;
        foreach (mMem[i]) mMem[i] = '0;

        waitCnt = 0;
        while (arstN !== 1'b1 && waitCnt < WAIT_LIMIT) begin
            @(negedge clk);
            waitCnt++;
        end
        if (arstN !== 1'b1) abortOnStall("arstN was never released");

        repeat (4) begin
            @(negedge clk);
            assert (pc == 32'd0) else begin
                errors++;
                $display("ERR pc: got %h, expected %h", pc, 32'd0);
            end
            assert (!instrAck && !wbValid) else begin
                errors++;
                $display("Core is busy after reset without any request");
            end
        end
        finishTest(1, "reset state");

        for (int i = 1; i < 32; i++) begin  // Random register contents
            send(iType(isaPkg::OP_LUI, 5'd0, i[4:0], randBits(16)), 0);
            send(iType(isaPkg::OP_ORI, i[4:0], i[4:0], randBits(16)), 0);
        end
        send(iType(isaPkg::OP_ADDIU, 5'd1, 5'd0, 16'h0005), 0);  // Write to register 0
        for (int i = 0; i < 60; i++) begin
            send(randomAluInstr(), 0);
        end
        finishTest(2, "ALU operations");

        for (int i = 0; i < 30; i++) begin
            idx8 = randBits(8);
            lane = randBits(2);
            case (randBits(2) % 3)
                0: send(iType(isaPkg::OP_SW, 5'd0, randBits(5), {6'd0, idx8, 2'b00}), 0);
                1: send(iType(isaPkg::OP_SH, 5'd0, randBits(5), {6'd0, idx8, lane[1], 1'b0}), 0);
                default: send(iType(isaPkg::OP_SB, 5'd0, randBits(5), {6'd0, idx8, lane}), 0);
            endcase
            lane = randBits(2);
            case (randBits(3) % 6)
                0: send(iType(isaPkg::OP_LB, 5'd0, randBits(5), {6'd0, idx8, lane}), 0);
                1: send(iType(isaPkg::OP_LBU, 5'd0, randBits(5), {6'd0, idx8, lane}), 0);
                2: send(iType(isaPkg::OP_LH, 5'd0, randBits(5), {6'd0, idx8, lane[1], 1'b0}), 0);
                3: send(iType(isaPkg::OP_LHU, 5'd0, randBits(5), {6'd0, idx8, lane[1], 1'b0}), 0);
                4: send(iType(isaPkg::OP_LW, 5'd0, randBits(5), {6'd0, idx8, 2'b00}), 0);
                default: send(iType(isaPkg::OP_LWU, 5'd0, randBits(5), {6'd0, idx8, 2'b00}), 0);
            endcase
        end
        finishTest(3, "loads and stores");

        for (int i = 0; i < 8; i++) begin
            r = randBits(5);
            send(iType(isaPkg::OP_BEQ, r, r, randBits(16)), 0);  // Taken
            send(iType(isaPkg::OP_BEQ, randBits(5), randBits(5), randBits(16)), 0);
            send(iType(isaPkg::OP_BNE, r, r, randBits(16)), 0);  // Not taken
            send(iType(isaPkg::OP_BNE, randBits(5), randBits(5), randBits(16)), 0);
            send(jType(isaPkg::OP_J, randBits(26)), 0);
            send(rType(isaPkg::FUNC_JR, randBits(5), 5'd0, 5'd0, 5'd0), 0);
        end
        finishTest(4, "branches and jumps");

        for (int i = 0; i < 6; i++) begin
            send(jType(isaPkg::OP_JAL, randBits(26)), 0);
            send(rType(isaPkg::FUNC_JALR, randBits(5), 5'd0, randBits(5), 5'd0), 0);
        end
        finishTest(5, "links");

        for (int i = 0; i < 20; i++) begin
            send(randomAluInstr(), randBits(3) + 1);  // Agent holds instrReq
        end
        finishTest(6, "held requests");

        $display("Summary: %0d instructions sent, %0d errors", sent, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end
endmodule

//--- verilog/Alu.sv
`timescale 1ns/1ps

module Alu (
    ctrlIf.alu          ctl,
    input  logic [31:0] instr,
    input  logic [31:0] rs,
    input  logic [31:0] rt,
    output logic [31:0] result,
    output logic        equal
);
    logic [31:0] immS;
    logic [31:0] immZ;
    logic [31:0] opB;
    logic        logicImm;

    assign immS     = {{16{instr[15]}}, instr[15:0]};
    assign immZ     = {16'd0, instr[15:0]};
    assign logicImm = ctl.aluOp inside {ctrlPkg::ALUOP_ANDI, ctrlPkg::ALUOP_ORI,
                                        ctrlPkg::ALUOP_XORI};
    assign opB      = !ctl.aluSrcImm ? rt : (logicImm ? immZ : immS);
    assign equal    = (rs == rt);  // Branch test

    always_comb begin
        case (ctl.aluOp)
            ctrlPkg::ALUOP_ADDI, ctrlPkg::ALUOP_ADDIU: result = rs + opB;
            ctrlPkg::ALUOP_LUI:   result = {instr[15:0], 16'd0};
            ctrlPkg::ALUOP_ANDI:  result = rs & opB;
            ctrlPkg::ALUOP_ORI:   result = rs | opB;
            ctrlPkg::ALUOP_XORI:  result = rs ^ opB;
            ctrlPkg::ALUOP_SLTI:  result = {31'd0, $signed(rs) < $signed(opB)};
            ctrlPkg::ALUOP_SLTIU: result = {31'd0, rs < opB};
            ctrlPkg::ALUOP_SRL:   result = rt >> instr[10:6];
            ctrlPkg::ALUOP_SRLV:  result = rt >> rs[4:0];
            // Branch offset, added to pc+4 by the sequencer
            ctrlPkg::ALUOP_BEQ, ctrlPkg::ALUOP_BNE: result = {immS[29:0], 2'b00};
            ctrlPkg::ALUOP_JUMP:  result = {4'd0, instr[25:0], 2'b00};
            ctrlPkg::ALUOP_ZERO: begin
                case (instr[5:0])
                    isaPkg::FUNC_ADDU: result = rs + opB;
                    isaPkg::FUNC_SUBU: result = rs - opB;
                    isaPkg::FUNC_AND:  result = rs & opB;
                    isaPkg::FUNC_OR:   result = rs | opB;
                    isaPkg::FUNC_XOR:  result = rs ^ opB;
                    isaPkg::FUNC_SLT:  result = {31'd0, $signed(rs) < $signed(opB)};
                    isaPkg::FUNC_SLL:  result = rt << instr[10:6];
                    default:           result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule

//--- verilog/Control.sv
`timescale 1ns/1ps

module Control (
    input  logic [31:0] instr,
    ctrlIf.dec          ctl
);
    logic [5:0] op;
    logic [5:0] func;

    assign op   = instr[31:26];
    assign func = instr[5:0];

    always_comb begin
        // NOP defaults
        ctl.aluOp      = ctrlPkg::ALUOP_ZERO;
        ctl.aluSrcImm  = 1'b0;
        ctl.branch     = ctrlPkg::BR_NONE;
        ctl.jump       = 1'b0;
        ctl.jumpReg    = 1'b0;
        ctl.regDst     = ctrlPkg::DST_RT;
        ctl.regWrite   = 1'b0;
        ctl.memRead    = 1'b0;
        ctl.memWrite   = 1'b0;
        ctl.width      = ctrlPkg::W_WORD;
        ctl.loadSigned = 1'b0;
        ctl.wbSrc      = ctrlPkg::WB_ALU;

        case (op)
            isaPkg::OP_J, isaPkg::OP_JAL: begin
                ctl.jump  = 1'b1;
                ctl.aluOp = ctrlPkg::ALUOP_JUMP;  // ALU builds the target
                if (op == isaPkg::OP_JAL) begin
                    ctl.regWrite = 1'b1;
                    ctl.regDst   = ctrlPkg::DST_LINK;
                    ctl.wbSrc    = ctrlPkg::WB_LINK;
                end
            end

            isaPkg::OP_BEQ, isaPkg::OP_BNE: begin
                ctl.branch = (op == isaPkg::OP_BEQ) ? ctrlPkg::BR_BEQ : ctrlPkg::BR_BNE;
                ctl.aluOp  = (op == isaPkg::OP_BEQ) ? ctrlPkg::ALUOP_BEQ : ctrlPkg::ALUOP_BNE;
            end

            isaPkg::OP_ZERO: begin
                case (func)
                    isaPkg::FUNC_JR, isaPkg::FUNC_JALR: begin
                        ctl.jump    = 1'b1;
                        ctl.jumpReg = 1'b1;
                        ctl.aluOp   = ctrlPkg::ALUOP_JUMP;
                        if (func == isaPkg::FUNC_JALR) begin
                            ctl.regWrite = 1'b1;
                            ctl.regDst   = ctrlPkg::DST_RD;
                            ctl.wbSrc    = ctrlPkg::WB_LINK;
                        end
                    end
                    isaPkg::FUNC_ADDU, isaPkg::FUNC_SUBU, isaPkg::FUNC_AND, isaPkg::FUNC_OR,
                    isaPkg::FUNC_XOR, isaPkg::FUNC_SLT, isaPkg::FUNC_SLL: begin
                        ctl.regWrite = 1'b1;
                        ctl.regDst   = ctrlPkg::DST_RD;
                    end
                    isaPkg::FUNC_SRL, isaPkg::FUNC_SRLV: begin
                        ctl.regWrite = 1'b1;
                        ctl.regDst   = ctrlPkg::DST_RD;
                        ctl.aluOp    = (func == isaPkg::FUNC_SRL) ? ctrlPkg::ALUOP_SRL
                                                                   : ctrlPkg::ALUOP_SRLV;
                    end
                    default: ;
                endcase
            end

            isaPkg::OP_ADDI, isaPkg::OP_ADDIU, isaPkg::OP_SLTI, isaPkg::OP_SLTIU,
            isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI, isaPkg::OP_LUI: begin
                ctl.aluSrcImm = 1'b1;
                ctl.regWrite  = 1'b1;
                case (op)
                    isaPkg::OP_ADDI:  ctl.aluOp = ctrlPkg::ALUOP_ADDI;  // No overflow trap
                    isaPkg::OP_ADDIU: ctl.aluOp = ctrlPkg::ALUOP_ADDIU;
                    isaPkg::OP_SLTI:  ctl.aluOp = ctrlPkg::ALUOP_SLTI;
                    isaPkg::OP_SLTIU: ctl.aluOp = ctrlPkg::ALUOP_SLTIU;
                    isaPkg::OP_ANDI:  ctl.aluOp = ctrlPkg::ALUOP_ANDI;
                    isaPkg::OP_ORI:   ctl.aluOp = ctrlPkg::ALUOP_ORI;
                    isaPkg::OP_XORI:  ctl.aluOp = ctrlPkg::ALUOP_XORI;
                    default:          ctl.aluOp = ctrlPkg::ALUOP_LUI;
                endcase
            end

            isaPkg::OP_LB, isaPkg::OP_LH, isaPkg::OP_LW,
            isaPkg::OP_LBU, isaPkg::OP_LHU, isaPkg::OP_LWU: begin
                ctl.aluSrcImm  = 1'b1;
                ctl.aluOp      = ctrlPkg::ALUOP_ADDI;  // Address sum
                ctl.memRead    = 1'b1;
                ctl.regWrite   = 1'b1;
                ctl.wbSrc      = ctrlPkg::WB_MEM;
                ctl.loadSigned = (op == isaPkg::OP_LB) || (op == isaPkg::OP_LH);
                ctl.width      = (op == isaPkg::OP_LB || op == isaPkg::OP_LBU) ? ctrlPkg::W_BYTE :
                                 (op == isaPkg::OP_LH || op == isaPkg::OP_LHU) ? ctrlPkg::W_HALF :
                                                                                 ctrlPkg::W_WORD;
            end

            isaPkg::OP_SB, isaPkg::OP_SH, isaPkg::OP_SW: begin
                ctl.aluSrcImm = 1'b1;
                ctl.aluOp     = ctrlPkg::ALUOP_ADDI;
                ctl.memWrite  = 1'b1;
                ctl.width     = (op == isaPkg::OP_SB) ? ctrlPkg::W_BYTE :
                                (op == isaPkg::OP_SH) ? ctrlPkg::W_HALF : ctrlPkg::W_WORD;
            end

            default: ;  // Unknown opcode stays inactive
        endcase
    end

    always_comb begin
        assert final (!(ctl.memRead && ctl.memWrite))
            else $error("Control: memRead and memWrite both set for %h", instr);
    end

endmodule

//--- verilog/DataMem.sv
`timescale 1ns/1ps

module DataMem (
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] addr,
    input  logic [31:0] storeData,
    ctrlIf.mem          ctl,
    output logic [31:0] loadData
);
    logic [31:0] mem [ctrlPkg::MEM_WORDS];
    logic [7:0]  idx;
    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  byteVal;

    assign idx     = addr[9:2];
    assign word    = mem[idx];
    assign half    = addr[1] ? word[31:16] : word[15:0];
    assign byteVal = word[{addr[1:0], 3'b000} +: 8];  // Little-endian lane

    always_comb begin
        if (!ctl.memRead) begin
            loadData = '0;
        end else begin
            case (ctl.width)
                ctrlPkg::W_HALF: loadData = {{16{ctl.loadSigned & half[15]}}, half};
                ctrlPkg::W_BYTE: loadData = {{24{ctl.loadSigned & byteVal[7]}}, byteVal};
                default:         loadData = word;
            endcase
        end
    end

    // --------------------
    // Lane writes
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < ctrlPkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (ctl.exec && ctl.memWrite) begin
            case (ctl.width)
                ctrlPkg::W_HALF: mem[idx][{addr[1], 4'b0000} +: 16] <= storeData[15:0];
                ctrlPkg::W_BYTE: mem[idx][{addr[1:0], 3'b000} +: 8] <= storeData[7:0];
                default:         mem[idx] <= storeData;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        ctl.exec && (ctl.memRead || ctl.memWrite) && (ctl.width == ctrlPkg::W_HALF)
        |-> !addr[0])
        else $error("DataMem: unaligned halfword access at %h", addr);

endmodule

//--- verilog/ExecCore.sv
`timescale 1ns/1ps

module ExecCore (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrReq,
    input  logic [31:0] instr,
    output logic        instrAck,
    output logic [31:0] pc,
    output logic        wbValid,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic [31:0] loadData;
    logic [31:0] wrData;
    logic [4:0]  destAddr;
    logic        equal;
    logic        wrEn;

    ctrlIf ctrlIf_inst ();

    always_comb begin
        case (ctrlIf_inst.regDst)
            ctrlPkg::DST_RD:   destAddr = instr[15:11];
            ctrlPkg::DST_LINK: destAddr = isaPkg::REG_LINK;
            default:           destAddr = instr[20:16];
        endcase
    end

    Control Control_inst (.instr(instr), .ctl(ctrlIf_inst.dec));

    RegFile RegFile_inst (
        .clk(clk), .arstN(arstN),
        .rdAddrA(instr[25:21]), .rdAddrB(instr[20:16]),
        .wrEn(wrEn), .wrAddr(destAddr), .wrData(wrData),
        .rdDataA(rsData), .rdDataB(rtData)
    );

    Alu Alu_inst (
        .ctl(ctrlIf_inst.alu), .instr(instr), .rs(rsData), .rt(rtData),
        .result(aluResult), .equal(equal)
    );

    DataMem DataMem_inst (
        .clk(clk), .arstN(arstN), .addr(aluResult), .storeData(rtData),
        .ctl(ctrlIf_inst.mem), .loadData(loadData)
    );

    InstrSeq InstrSeq_inst (
        .clk(clk), .arstN(arstN), .instrReq(instrReq), .equal(equal),
        .rs(rsData), .aluResult(aluResult), .loadData(loadData), .destAddr(destAddr),
        .ctl(ctrlIf_inst.seq), .instrAck(instrAck), .pc(pc),
        .wrEn(wrEn), .wrData(wrData),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
    );

endmodule

//--- verilog/InstrSeq.sv
`timescale 1ns/1ps

module InstrSeq (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrReq,
    input  logic        equal,
    input  logic [31:0] rs,
    input  logic [31:0] aluResult,
    input  logic [31:0] loadData,
    input  logic [4:0]  destAddr,
    ctrlIf.seq          ctl,
    output logic        instrAck,
    output logic [31:0] pc,
    output logic        wrEn,
    output logic [31:0] wrData,
    output logic        wbValid,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);
    typedef enum logic [1:0] {IDLE, ACKED, RELEASE} stateT;

    stateT       state;
    logic        exec;
    logic        taken;
    logic [31:0] pcPlus4;
    logic [31:0] nextPc;

    assign exec     = (state == IDLE) && instrReq;  // Execution edge
    assign ctl.exec = exec;
    assign instrAck = (state != IDLE);
    assign wrEn     = exec && ctl.regWrite;
    assign pcPlus4  = pc + 32'd4;
    assign taken    = ((ctl.branch == ctrlPkg::BR_BEQ) && equal) ||
                      ((ctl.branch == ctrlPkg::BR_BNE) && !equal);

    always_comb begin
        if (ctl.jump) begin
            nextPc = ctl.jumpReg ? rs : {pcPlus4[31:28], aluResult[27:0]};
        end else if (taken) begin
            nextPc = pcPlus4 + aluResult;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_comb begin
        case (ctl.wbSrc)
            ctrlPkg::WB_MEM:  wrData = loadData;
            ctrlPkg::WB_LINK: wrData = pcPlus4;  // No delay slot
            default:          wrData = aluResult;
        endcase
    end

    // --------------------
    // Handshake and PC
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= IDLE;
            pc      <= '0;
            wbValid <= 1'b0;
        end else begin
            wbValid <= wrEn && (destAddr != 5'd0);
            case (state)
                IDLE: begin
                    if (instrReq) begin
                        state <= ACKED;
                        pc    <= nextPc;
                    end
                end
                ACKED:   if (!instrReq) state <= RELEASE;
                default: state <= IDLE;  // Drop ack
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (exec) begin
            wbAddr <= destAddr;
            wbData <= wrData;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        $fell(instrAck) |-> !instrReq && !$past(instrReq))
        else $error("InstrSeq: instrAck dropped while instrReq was high");

endmodule

//--- verilog/RegFile.sv
`timescale 1ns/1ps

module RegFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);
    logic [31:0] regs [32];

    assign rdDataA = regs[rdAddrA];  // Asynchronous reads
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Holds through every write to index 0
    assert property (@(posedge clk) disable iff (!arstN) regs[0] == 32'd0)
        else $error("RegFile: register 0 is %h", regs[0]);

endmodule

//--- verilog/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
    ctrlPkg::aluOpT  aluOp;
    logic            aluSrcImm;
    ctrlPkg::branchT branch;
    logic            jump;
    logic            jumpReg;    // Target from rs
    ctrlPkg::regDstT regDst;
    logic            regWrite;
    logic            memRead;
    logic            memWrite;
    ctrlPkg::widthT  width;
    logic            loadSigned;
    ctrlPkg::wbSrcT  wbSrc;
    logic            exec;       // Execution strobe from the sequencer

    modport dec (output aluOp, aluSrcImm, branch, jump, jumpReg, regDst, regWrite,
                 memRead, memWrite, width, loadSigned, wbSrc);
    modport alu (input aluOp, aluSrcImm);
    modport mem (input memRead, memWrite, width, loadSigned, exec);
    modport seq (input branch, jump, jumpReg, regWrite, wbSrc, output exec);
endinterface

//--- verilog/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [5:0] {
        ALUOP_ZERO  = 6'b000000,  // Decode function field
        ALUOP_ADDIU = 6'b000001,
        ALUOP_ADDI  = 6'b000010,
        ALUOP_LUI   = 6'b000100,
        ALUOP_BEQ   = 6'b000110,
        ALUOP_BNE   = 6'b000111,
        ALUOP_JUMP  = 6'b001011,  // J, JAL, JR, JALR
        ALUOP_ANDI  = 6'b001100,
        ALUOP_ORI   = 6'b001101,
        ALUOP_XORI  = 6'b001110,
        ALUOP_SLTI  = 6'b010000,
        ALUOP_SLTIU = 6'b010001,
        ALUOP_SRL   = 6'b010010,
        ALUOP_SRLV  = 6'b010100
    } aluOpT;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2
    } branchT;

    typedef enum logic [1:0] {W_WORD = 2'b00, W_HALF = 2'b01, W_BYTE = 2'b10} widthT;

    typedef enum logic [1:0] {DST_RT = 2'b00, DST_RD = 2'b01, DST_LINK = 2'b10} regDstT;

    typedef enum logic [1:0] {WB_MEM = 2'b00, WB_LINK = 2'b01, WB_ALU = 2'b10} wbSrcT;

    localparam int MEM_WORDS = 256;  // Data memory depth in words

endpackage

//--- verilog/isaPkg.sv
package isaPkg;

    // --------------------
    // Opcodes
    // --------------------
    localparam logic [5:0] OP_ZERO  = 6'b000000;  // R-type
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_JAL   = 6'b000011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_SLTIU = 6'b001011;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_LB    = 6'b100000;
    localparam logic [5:0] OP_LH    = 6'b100001;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_LBU   = 6'b100100;
    localparam logic [5:0] OP_LHU   = 6'b100101;
    localparam logic [5:0] OP_LWU   = 6'b100111;  // Same as LW here
    localparam logic [5:0] OP_SB    = 6'b101000;
    localparam logic [5:0] OP_SH    = 6'b101001;
    localparam logic [5:0] OP_SW    = 6'b101011;

    // --------------------
    // Function field
    // --------------------
    localparam logic [5:0] FUNC_SLL  = 6'b000000;
    localparam logic [5:0] FUNC_SRL  = 6'b000010;
    localparam logic [5:0] FUNC_SRLV = 6'b000110;
    localparam logic [5:0] FUNC_JR   = 6'b001000;
    localparam logic [5:0] FUNC_JALR = 6'b001001;
    localparam logic [5:0] FUNC_ADDU = 6'b100001;
    localparam logic [5:0] FUNC_SUBU = 6'b100011;
    localparam logic [5:0] FUNC_AND  = 6'b100100;
    localparam logic [5:0] FUNC_OR   = 6'b100101;
    localparam logic [5:0] FUNC_XOR  = 6'b100110;
    localparam logic [5:0] FUNC_SLT  = 6'b101010;

    localparam logic [4:0] REG_LINK = 5'd31;  // JAL destination

endpackage
